// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_vec_unit
FILELIST  ?= vec_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= PASS: all tests

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_vec_unit.sv ====
// Runs dv/vec_cases.txt from the project root; expected values assume NrLanes 4 and VLEN 512
`timescale 1ns/100ps

module tb_vec_unit import vec_pkg::*; ();

  localparam int unsigned NrLanes  = 4;
  localparam int unsigned VLEN     = 512;
  localparam int unsigned MaxCases = 64;
  localparam int unsigned Timeout  = 100;

  logic      clk_i = 1'b0;
  logic      reset_i;
  logic      insn_valid_i;
  vec_insn_u insn_i;
  vec_elem_t scalar_i;
  logic      insn_ready_o;
  logic      resp_valid_o;
  vec_elem_t resp_data_o;

  // Four words per case in the order insn, scalar, response flag and expected value
  logic [31:0] case_mem [4*MaxCases];
  int unsigned num_cases;
  int unsigned num_checks;

  always #5 clk_i = ~clk_i;

  vec_unit #(
    .NrLanes (NrLanes),
    .VLEN    (VLEN   )
  ) i_dut (
    .clk_i        (clk_i       ),
    .reset_i      (reset_i     ),
    .insn_valid_i (insn_valid_i),
    .insn_i       (insn_i      ),
    .scalar_i     (scalar_i    ),
    .insn_ready_o (insn_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_data_o  (resp_data_o )
  );

  ////////////////////////////////////////////////////////////
  // Reporting and compares
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_resp(input vec_elem_t got, input vec_elem_t exp, input string what);
    num_checks++;
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t ns: %s, got %08h, expected %08h",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_vl(input vec_vl_t got, input vec_vl_t exp, input string what);
    num_checks++;
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t ns: %s, got vl %0d, expected vl %0d",
                          $time, what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Called right after a rising edge
  // Valid stays high while a case waits
  task automatic drive_case(input int unsigned idx);
    if (idx < num_cases) begin
      insn_valid_i <= 1'b1;
      insn_i       <= case_mem[4*idx];
      scalar_i     <= case_mem[4*idx+1];
    end else begin
      insn_valid_i <= 1'b0;
      insn_i       <= '0;
      scalar_i     <= '0;
    end
  endtask

  // Starts and ends on a falling edge
  task automatic wait_ready(input int unsigned idx);
    int unsigned cycles;
    cycles = 0;
    while (!insn_ready_o) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > Timeout) begin
        abort_run($sformatf("Timeout: case %0d was never accepted", idx));
      end
    end
  endtask

  // Follows the accepting edge until insn_ready_o returns
  task automatic wait_done(input int unsigned idx);
    int unsigned cycles;
    logic        want_resp;
    logic        is_setvl;
    logic        got_resp;
    vec_elem_t   exp;
    want_resp = case_mem[4*idx+2][0];
    is_setvl  = case_mem[4*idx][31];
    exp       = case_mem[4*idx+3];
    got_resp  = 1'b0;
    cycles    = 0;
    @(negedge clk_i);
    if (insn_ready_o) begin
      abort_run($sformatf("Case %0d was accepted but insn_ready_o stayed high", idx));
    end
    while (!insn_ready_o) begin
      if (resp_valid_o) begin
        if (!want_resp) begin
          abort_run($sformatf("Case %0d gave a response where none was expected", idx));
        end
        if (is_setvl) begin
          check_vl(vec_vl_t'(resp_data_o), vec_vl_t'(exp), $sformatf("case %0d setvl", idx));
          // The new vl comes back zero extended to a full element
          check_resp(resp_data_o >> $bits(vec_vl_t), '0,
                     $sformatf("case %0d setvl upper bits", idx));
        end else begin
          check_resp(resp_data_o, exp, $sformatf("case %0d response", idx));
        end
        got_resp = 1'b1;
      end
      @(negedge clk_i);
      cycles++;
      if (cycles > Timeout) begin
        abort_run($sformatf("Timeout: case %0d did not complete", idx));
      end
    end
    if (resp_valid_o) begin
      abort_run($sformatf("Case %0d response came while insn_ready_o was high", idx));
    end
    if (want_resp && !got_resp) begin
      abort_run($sformatf("Case %0d completed without a response", idx));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    bit found_end;
    reset_i      <= 1'b1;
    insn_valid_i <= 1'b0;
    insn_i       <= '0;
    scalar_i     <= '0;
    num_checks = 0;
    num_cases  = 0;
    found_end  = 1'b0;
    $readmemh("dv/vec_cases.txt", case_mem);
    // Flag value F marks the end of the list
    for (int i = 0; i < MaxCases; i++) begin
      if (!found_end) begin
        if (case_mem[4*i+2] == 32'hF) begin
          found_end = 1'b1;
        end else begin
          num_cases++;
        end
      end
    end
    if (!found_end) begin
      abort_run("The cases file has no end marker or could not be read");
    end
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    drive_case(0);
    @(negedge clk_i);
    for (int unsigned k = 0; k < num_cases; k++) begin
      wait_ready(k);
      @(posedge clk_i);
      drive_case(k + 1);
      wait_done(k);
    end
    if (num_checks > 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      abort_run("No result was checked");
    end
  end

endmodule : tb_vec_unit

// ==== dv/vec_cases.txt ====
// insn_word scalar resp_flag expected   (flag 1 = response expected, 0 = none, F = end)
// Arith word: op[30:27] vd[26:24] vs1[23:21] vs2[20:18]; setvl word: 8000_0000 | avl
80000005 00000000 1 00000005
80000010 00000000 1 00000010
80000028 00000000 1 00000010
29000000 00000007 0 00000000
2A000000 0000000C 0 00000000
2B000000 F0F0A5A5 0 00000000
// Ext of every index, cycling through v1, v2, v3
38040000 00000000 1 00000007
38080000 00000001 1 0000000C
380C0000 00000002 1 F0F0A5A5
38040000 00000003 1 00000007
38080000 00000004 1 0000000C
380C0000 00000005 1 F0F0A5A5
38040000 00000006 1 00000007
38080000 00000007 1 0000000C
380C0000 00000008 1 F0F0A5A5
38040000 00000009 1 00000007
38080000 0000000A 1 0000000C
380C0000 0000000B 1 F0F0A5A5
38040000 0000000C 1 00000007
38080000 0000000D 1 0000000C
380C0000 0000000E 1 F0F0A5A5
38040000 0000000F 1 00000007
38080000 00000010 1 00000000
// v4 = v3 + v1, v5 = v1 - v2, v6 = v3 & v2, v7 = v3 | v1, v0 = v3 ^ v2
042C0000 00000000 0 00000000
0D440000 00000000 0 00000000
164C0000 00000000 0 00000000
1F2C0000 00000000 0 00000000
204C0000 00000000 0 00000000
38100000 0000000D 1 F0F0A5AC
38140000 00000006 1 FFFFFFFB
38180000 00000003 1 00000004
381C0000 0000000A 1 F0F0A5A7
38000000 0000000F 1 F0F0A5A9
// Tail stays at 7 above vl 6
80000006 00000000 1 00000006
29000000 00000064 0 00000000
38040000 00000005 1 00000064
38040000 00000006 1 00000007
38040000 0000000F 1 00000007
// Redsum at vl 6, 16, 0 and 3
30040000 00001000 1 00001258
80000010 00000000 1 00000010
30040000 00001000 1 0000129E
300C0000 20000000 1 2F0A5A50
80000000 00000000 1 00000000
30040000 DEADBEEF 1 DEADBEEF
80000003 00000000 1 00000003
30140000 00000005 1 FFFFFFF6
00000000 00000000 F 00000000

// ==== dv/vec_unit_sva.sv ====
// Port-level protocol checks for vec_unit; assumes one instruction in flight at a time
`timescale 1ns/100ps

module vec_unit_sva (
  input logic clk_i,
  input logic reset_i,
  input logic insn_valid_i,
  input logic insn_ready_i,
  input logic resp_valid_i
);

  ////////////////////////////////////////////////////////////
  // Handshake and response
  ////////////////////////////////////////////////////////////

  resp_one_cycle_a: assert property (
    @(posedge clk_i) disable iff (reset_i) resp_valid_i |=> !resp_valid_i
  ) else $error("resp_valid_o held high for more than one cycle");

  // First cycle out of reset must accept
  ready_after_reset_a: assert property (
    @(posedge clk_i) $fell(reset_i) |-> insn_ready_i
  ) else $error("insn_ready_o low in the first cycle after reset");

  busy_after_accept_a: assert property (
    @(posedge clk_i) disable iff (reset_i) (insn_valid_i && insn_ready_i) |=> !insn_ready_i
  ) else $error("insn_ready_o high right after an accepted instruction");

  // A response closes the instruction, ready returns next cycle
  ready_after_resp_a: assert property (
    @(posedge clk_i) disable iff (reset_i) resp_valid_i |=> insn_ready_i
  ) else $error("insn_ready_o did not return after the response");

  no_resp_when_idle_a: assert property (
    @(posedge clk_i) disable iff (reset_i) $rose(resp_valid_i) |-> !insn_ready_i
  ) else $error("resp_valid_o rose while insn_ready_o was high");

endmodule : vec_unit_sva

bind vec_unit vec_unit_sva i_sva (
  .clk_i        (clk_i       ),
  .reset_i      (reset_i     ),
  .insn_valid_i (insn_valid_i),
  .insn_ready_i (insn_ready_o),
  .resp_valid_i (resp_valid_o)
);

// ==== source/vec_dispatcher.sv ====
// Input side; one instruction in flight at a time, avl above VLMAX is clamped to VLMAX
`timescale 1ns/100ps

module vec_dispatcher import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VLEN    = 512
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       insn_valid_i,
  input  vec_insn_u  insn_i,
  input  vec_elem_t  scalar_i,
  output logic       insn_ready_o,
  vec_lane_if.disp   lanes,
  output logic       setvl_valid_o,
  output vec_vl_t    new_vl_o
);

  localparam int unsigned VLMAX = VLEN / ElemWidth;

  logic      busy_q;
  logic      resp_pend_q;
  logic      issue_q;
  logic      setvl_valid_q;
  vec_vl_t   vl_q;
  vec_op_e   op_q;
  vreg_idx_t vd_q;
  vreg_idx_t vs1_q;
  vreg_idx_t vs2_q;
  vec_elem_t scalar_q;

  logic      accept;
  logic      lanes_done;
  logic      wants_resp;
  vec_vl_t   avl_clamped;

  assign insn_ready_o = ~busy_q;
  assign accept       = insn_valid_i & ~busy_q;

  // Lanes step in lockstep, all flags rise together
  always_comb begin
    lanes_done = 1'b1;
    for (int l = 0; l < NrLanes; l++) begin
      lanes_done = lanes_done & lanes.lane_done[l];
    end
  end

  assign wants_resp  = (op_q == OP_REDSUM) || (op_q == OP_EXT);
  assign avl_clamped = (insn_i.cfg.avl > vec_vl_t'(VLMAX)) ? vec_vl_t'(VLMAX)
                                                            : insn_i.cfg.avl;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  // Busy drops one cycle after the completion pulse is visible
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q        <= 1'b0;
      resp_pend_q   <= 1'b0;
      issue_q       <= 1'b0;
      setvl_valid_q <= 1'b0;
      vl_q          <= '0;
      op_q          <= OP_ADD;
    end else begin
      issue_q       <= 1'b0;
      setvl_valid_q <= 1'b0;
      if (accept) begin
        busy_q <= 1'b1;
        if (insn_i.cfg.cls) begin
          vl_q          <= avl_clamped;
          op_q          <= OP_SETVL;
          setvl_valid_q <= 1'b1;
        end else begin
          op_q    <= insn_i.arith.op;
          issue_q <= 1'b1;
        end
      end else if (resp_pend_q) begin
        busy_q      <= 1'b0;
        resp_pend_q <= 1'b0;
      end else if (setvl_valid_q || (lanes_done && wants_resp)) begin
        resp_pend_q <= 1'b1;
      end else if (lanes_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Operand fields
  always_ff @(posedge clk_i) begin
    if (accept && !insn_i.arith.cls) begin
      vd_q     <= insn_i.arith.vd;
      vs1_q    <= insn_i.arith.vs1;
      vs2_q    <= insn_i.arith.vs2;
      scalar_q <= scalar_i;
    end
  end

  assign lanes.issue  = issue_q;
  assign lanes.op     = op_q;
  assign lanes.vd     = vd_q;
  assign lanes.vs1    = vs1_q;
  assign lanes.vs2    = vs2_q;
  assign lanes.scalar = scalar_q;
  assign lanes.vl     = vl_q;

  assign setvl_valid_o = setvl_valid_q;
  assign new_vl_o      = vl_q;

endmodule : vec_dispatcher

// ==== source/vec_lane.sv ====
// One lane; element e lives here when e mod NrLanes equals lane_id, register file is not reset
`timescale 1ns/100ps

module vec_lane import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VLEN    = 512,
  parameter int unsigned lane_id = 0
) (
  input  logic     clk_i,
  input  logic     reset_i,
  vec_lane_if.lane lanes
);

  localparam int unsigned VLMAX       = VLEN / ElemWidth;
  localparam int unsigned RowsPerLane = VLMAX / NrLanes;
  localparam int unsigned RowW        = (RowsPerLane > 1) ? $clog2(RowsPerLane) : 1;
  localparam int unsigned LaneShift   = $clog2(NrLanes);

  vec_elem_t vrf [NrVRegs][RowsPerLane];

  logic            active_q;
  logic            done_q;
  logic [RowW-1:0] row_q;
  vec_elem_t       acc_q;

  vec_vl_t         rows_needed;
  logic [RowW-1:0] last_row;
  vec_vl_t         gidx;
  logic            elem_active;
  logic            ext_hit;
  logic            writes_vd;
  vec_elem_t       elem_a;
  vec_elem_t       elem_b;
  vec_elem_t       alu_res;

  ////////////////////////////////////////////////////////////
  // Row sequencing
  ////////////////////////////////////////////////////////////

  // Ext scans every row since its index ignores vl
  always_comb begin
    rows_needed = (lanes.vl + vec_vl_t'(NrLanes - 1)) >> LaneShift;
    if (lanes.op == OP_EXT) begin
      rows_needed = vec_vl_t'(RowsPerLane);
    end
    if (rows_needed == '0) begin
      rows_needed = vec_vl_t'(1);
    end
    last_row = RowW'(rows_needed - vec_vl_t'(1));
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      row_q    <= '0;
    end else begin
      done_q <= 1'b0;
      if (lanes.issue) begin
        active_q <= 1'b1;
        row_q    <= '0;
      end else if (active_q) begin
        if (row_q == last_row) begin
          active_q <= 1'b0;
          done_q   <= 1'b1;
        end else begin
          row_q <= row_q + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Element ALU
  ////////////////////////////////////////////////////////////

  assign gidx        = vec_vl_t'(row_q) * vec_vl_t'(NrLanes) + vec_vl_t'(lane_id);
  assign elem_active = gidx < lanes.vl;
  assign ext_hit     = vec_elem_t'(gidx) == lanes.scalar;
  assign writes_vd   = lanes.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SPLAT};

  always_comb begin
    elem_a = vrf[lanes.vs2][row_q];
    elem_b = vrf[lanes.vs1][row_q];
    case (lanes.op)
      OP_ADD:   alu_res = elem_a + elem_b;
      // vs2 minus vs1, as in vsub.vv
      OP_SUB:   alu_res = elem_a - elem_b;
      OP_AND:   alu_res = elem_a & elem_b;
      OP_OR:    alu_res = elem_a | elem_b;
      OP_XOR:   alu_res = elem_a ^ elem_b;
      OP_SPLAT: alu_res = lanes.scalar;
      default:  alu_res = elem_a;
    endcase
  end

  // Tail elements are left untouched
  always_ff @(posedge clk_i) begin
    if (active_q && elem_active && writes_vd) begin
      vrf[lanes.vd][row_q] <= alu_res;
    end
  end

  // Partial sum for redsum, owned element for ext
  always_ff @(posedge clk_i) begin
    if (lanes.issue) begin
      acc_q <= '0;
    end else if (active_q && (lanes.op == OP_REDSUM) && elem_active) begin
      acc_q <= acc_q + elem_a;
    end else if (active_q && (lanes.op == OP_EXT) && ext_hit) begin
      acc_q <= elem_a;
    end
  end

  assign lanes.lane_done[lane_id]    = done_q;
  assign lanes.lane_contrib[lane_id] = acc_q;

endmodule : vec_lane

// ==== source/vec_lane_if.sv ====
// Lane bus; all lanes finish on the same cycle, so consumers may AND the done flags
`timescale 1ns/100ps

interface vec_lane_if import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4
) ();

  // Operation broadcast, held stable while the instruction is in flight
  logic      issue;
  vec_op_e   op;
  vreg_idx_t vd;
  vreg_idx_t vs1;
  vreg_idx_t vs2;
  vec_elem_t scalar;
  vec_vl_t   vl;

  // One entry per lane
  logic      lane_done    [NrLanes];
  vec_elem_t lane_contrib [NrLanes];

  modport disp (
    output issue, op, vd, vs1, vs2, scalar, vl,
    input  lane_done
  );

  modport lane (
    input  issue, op, vd, vs1, vs2, scalar, vl,
    output lane_done, lane_contrib
  );

  modport result (
    input op, scalar, lane_done, lane_contrib
  );

endinterface : vec_lane_if

// ==== source/vec_pkg.sv ====
// Shared vec_unit types; element width is fixed at 32 bits and vl is held in 16 bits
package vec_pkg;

  ////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////

  localparam int unsigned ElemWidth = 32;
  localparam int unsigned NrVRegs   = 8;

  typedef logic [ElemWidth-1:0]       vec_elem_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_idx_t;
  typedef logic [15:0]                vec_vl_t;

  // Operation codes, OP_SETVL is only used internally for the cfg class
  typedef enum logic [3:0] {
    OP_ADD    = 4'h0,
    OP_SUB    = 4'h1,
    OP_AND    = 4'h2,
    OP_OR     = 4'h3,
    OP_XOR    = 4'h4,
    OP_SPLAT  = 4'h5,
    OP_REDSUM = 4'h6,
    OP_EXT    = 4'h7,
    OP_SETVL  = 4'h8
  } vec_op_e;

  ////////////////////////////////////////////////////////////
  // Instruction word
  ////////////////////////////////////////////////////////////

  // Arithmetic view, class bit is zero
  typedef struct packed {
    logic        cls;
    vec_op_e     op;
    vreg_idx_t   vd;
    vreg_idx_t   vs1;
    vreg_idx_t   vs2;
    logic [17:0] rsvd;
  } vec_arith_t;

  // Configuration view, class bit is one
  typedef struct packed {
    logic        cls;
    logic [14:0] rsvd;
    vec_vl_t     avl;
  } vec_cfg_t;

  // Bit 31 picks which view applies
  typedef union packed {
    vec_arith_t arith;
    vec_cfg_t   cfg;
  } vec_insn_u;

endpackage : vec_pkg

// ==== source/vec_result_unit.sv ====
// Output side; one-cycle response pulse with no back-pressure, arithmetic ops give no response
`timescale 1ns/100ps

module vec_result_unit import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic       clk_i,
  input  logic       reset_i,
  vec_lane_if.result lanes,
  input  logic       setvl_valid_i,
  input  vec_vl_t    new_vl_i,
  output logic       resp_valid_o,
  output vec_elem_t  resp_data_o
);

  logic      resp_valid_q;
  vec_elem_t resp_data_q;
  logic      all_done;
  logic      scalar_op;
  vec_elem_t lane_sum;

  ////////////////////////////////////////////////////////////
  // Lane combine
  ////////////////////////////////////////////////////////////

  // Ext contributions are zero except in the owning lane
  always_comb begin
    all_done = 1'b1;
    lane_sum = '0;
    for (int l = 0; l < NrLanes; l++) begin
      all_done = all_done & lanes.lane_done[l];
      lane_sum = lane_sum + lanes.lane_contrib[l];
    end
    if (lanes.op == OP_REDSUM) begin
      lane_sum = lane_sum + lanes.scalar;
    end
  end

  assign scalar_op = (lanes.op == OP_REDSUM) || (lanes.op == OP_EXT);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= setvl_valid_i || (all_done && scalar_op);
    end
  end

  always_ff @(posedge clk_i) begin
    if (setvl_valid_i) begin
      resp_data_q <= vec_elem_t'(new_vl_i);
    end else if (all_done && scalar_op) begin
      resp_data_q <= lane_sum;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_data_o  = resp_data_q;

endmodule : vec_result_unit

// ==== source/vec_unit.sv ====
// Vector coprocessor top; NrLanes must be a power of two dividing VLEN/32, one insn at a time
`timescale 1ns/100ps

module vec_unit import vec_pkg::*; #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned VLEN    = 512
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      insn_valid_i,
  input  vec_insn_u insn_i,
  input  vec_elem_t scalar_i,
  output logic      insn_ready_o,
  output logic      resp_valid_o,
  output vec_elem_t resp_data_o
);

  localparam int unsigned VLMAX = VLEN / ElemWidth;

  logic    setvl_valid;
  vec_vl_t new_vl;

  vec_lane_if #(.NrLanes(NrLanes)) lanes_if ();

  vec_dispatcher #(
    .NrLanes (NrLanes),
    .VLEN    (VLEN   )
  ) i_dispatcher (
    .clk_i         (clk_i       ),
    .reset_i       (reset_i     ),
    .insn_valid_i  (insn_valid_i),
    .insn_i        (insn_i      ),
    .scalar_i      (scalar_i    ),
    .insn_ready_o  (insn_ready_o),
    .lanes         (lanes_if    ),
    .setvl_valid_o (setvl_valid ),
    .new_vl_o      (new_vl      )
  );

  for (genvar lane = 0; lane < NrLanes; lane++) begin : gen_lanes
    vec_lane #(
      .NrLanes (NrLanes),
      .VLEN    (VLEN   ),
      .lane_id (lane   )
    ) i_lane (
      .clk_i   (clk_i   ),
      .reset_i (reset_i ),
      .lanes   (lanes_if)
    );
  end : gen_lanes

  vec_result_unit #(
    .NrLanes (NrLanes)
  ) i_result (
    .clk_i         (clk_i       ),
    .reset_i       (reset_i     ),
    .lanes         (lanes_if    ),
    .setvl_valid_i (setvl_valid ),
    .new_vl_i      (new_vl      ),
    .resp_valid_o  (resp_valid_o),
    .resp_data_o   (resp_data_o )
  );

  ////////////////////////////////////////////////////////////
  // Elaboration checks
  ////////////////////////////////////////////////////////////

  if (NrLanes == 0 || NrLanes != 2 ** $clog2(NrLanes)) begin : gen_chk_lanes
    $error("vec_unit: NrLanes must be a nonzero power of two");
  end

  if (VLMAX == 0 || (VLMAX % NrLanes) != 0) begin : gen_chk_vlmax
    $error("vec_unit: VLEN/ElemWidth must be a nonzero multiple of NrLanes");
  end

endmodule : vec_unit

// ==== vec_unit.f ====
source/vec_pkg.sv
source/vec_lane_if.sv
source/vec_dispatcher.sv
source/vec_lane.sv
source/vec_result_unit.sv
source/vec_unit.sv
dv/vec_unit_sva.sv
dv/tb_vec_unit.sv
